// ==== hw/mcache_macros.svh ====
`ifndef MCACHE_MACROS_SVH
`define MCACHE_MACROS_SVH

// cache geometry
`define MC_WAYS 4
`define MC_SETS 16

// index selects one of MC_SETS sets
`define MC_IDX_W 4

// what is left of a 32-bit address after index and byte offset
`define MC_TAG_W (32 - `MC_IDX_W - 2)

`endif

// ==== hw/mcache_pkg.sv ====
`include "mcache_macros.svh"

package mcache_pkg;

    // tag / index / offset view of an address
    typedef struct packed {
        logic [`MC_TAG_W-1:0] tag;
        logic [`MC_IDX_W-1:0] index;
        logic [1:0]           offset;
    } addr_fields_t;

    // same word seen as a flat address or as lookup fields
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } cache_addr_u;

    typedef struct packed {
        cache_addr_u addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        write;
        logic        uncache;
    } cpu_req_t;

    typedef enum logic {
        SRC_INST = 1'b0,
        SRC_DATA = 1'b1
    } req_src_e;

    typedef struct packed {
        logic        hit;
        logic [31:0] data;
    } way_resp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        write;
    } mem_req_t;

endpackage

// ==== hw/req_arbiter.sv ====
`timescale 1ns/1ps

module req_arbiter (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_ireq,
    input  logic [31:0]           i_iaddr,
    input  logic                  i_dreq,
    input  mcache_pkg::cpu_req_t  i_dreq_data,
    input  logic                  i_idle,
    input  logic                  i_done,
    output logic                  o_iack,
    output logic                  o_dack,
    output logic                  o_lookup,
    output mcache_pkg::cpu_req_t  o_req,
    output mcache_pkg::req_src_e  o_src
);
    typedef enum logic [1:0] {A_IDLE, A_BUSY, A_ACK} arb_state_e;

    arb_state_e           state;
    mcache_pkg::cpu_req_t sel_req;
    logic                 grant;
    logic                 cur_req;

    // fetches are plain cached word reads
    always_comb begin
        sel_req = i_dreq_data;
        if (!i_dreq) begin
            sel_req.addr.raw = i_iaddr;
            sel_req.wdata    = 32'h0;
            sel_req.wstrb    = 4'b1111;
            sel_req.write    = 1'b0;
            sel_req.uncache  = 1'b0;
        end
    end

    assign grant   = (state == A_IDLE) && i_idle && (i_ireq || i_dreq);
    assign cur_req = (o_src == mcache_pkg::SRC_DATA) ? i_dreq : i_ireq;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state    <= A_IDLE;
            o_lookup <= 1'b0;
            o_iack   <= 1'b0;
            o_dack   <= 1'b0;
            o_src    <= mcache_pkg::SRC_INST;
        end else begin
            o_lookup <= grant;
            case (state)
                A_IDLE: if (grant) begin
                    o_src <= i_dreq ? mcache_pkg::SRC_DATA : mcache_pkg::SRC_INST;
                    state <= A_BUSY;
                end
                A_BUSY: if (i_done) begin
                    o_dack <= (o_src == mcache_pkg::SRC_DATA);
                    o_iack <= (o_src == mcache_pkg::SRC_INST);
                    state  <= A_ACK;
                end
                // hold ack until the granted port lets go
                default: if (!cur_req) begin
                    o_iack <= 1'b0;
                    o_dack <= 1'b0;
                    state  <= A_IDLE;
                end
            endcase
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (grant) begin
            o_req <= sel_req;
        end
    end

endmodule

// ==== hw/cache_way.sv ====
`timescale 1ns/1ps
`include "mcache_macros.svh"

module cache_way (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_lookup,
    input  mcache_pkg::cpu_req_t  i_req,
    input  logic                  i_fill_we,
    input  logic                  i_store_we,
    input  logic [31:0]           i_fill_data,
    output mcache_pkg::way_resp_t o_resp
);
    logic [`MC_TAG_W-1:0] tag_mem [`MC_SETS];
    logic [31:0]          data_mem [`MC_SETS];
    logic [`MC_SETS-1:0]  valid;
    logic [`MC_TAG_W-1:0] tag_q;
    logic [31:0]          data_q;
    logic                 valid_q;
    logic [31:0]          store_word;
    logic [`MC_IDX_W-1:0] idx;

    assign idx = i_req.addr.f.index;

    // merge store bytes into the line read at lookup
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            store_word[8*b +: 8] = i_req.wstrb[b] ? i_req.wdata[8*b +: 8] : data_q[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid   <= '0;
            valid_q <= 1'b0;
        end else begin
            if (i_lookup) begin
                valid_q <= valid[idx];
            end
            if (i_fill_we) begin
                valid[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_lookup) begin
            tag_q  <= tag_mem[idx];
            data_q <= data_mem[idx];
        end
        if (i_fill_we) begin
            tag_mem[idx]  <= i_req.addr.f.tag;
            data_mem[idx] <= i_fill_data;
        end else if (i_store_we && valid[idx]) begin
            data_mem[idx] <= store_word;
        end
    end

    assign o_resp.hit  = valid_q && (tag_q == i_req.addr.f.tag);
    assign o_resp.data = data_q;

endmodule

// ==== hw/way_select.sv ====
`timescale 1ns/1ps
`include "mcache_macros.svh"

module way_select #(
    parameter int WAY_W = $clog2(`MC_WAYS)
) (
    input  logic                                     clk,
    input  logic                                     i_rst_n,
    input  mcache_pkg::way_resp_t [`MC_WAYS-1:0]     i_resp,
    input  logic [`MC_IDX_W-1:0]                     i_index,
    input  logic                                     i_fill_done,
    output logic                                     o_hit,
    output logic [WAY_W-1:0]                         o_hit_way,
    output logic [31:0]                              o_hit_data,
    output logic [WAY_W-1:0]                         o_victim
);
    // round-robin victim pointer, one per set
    logic [WAY_W-1:0] rr_ptr [`MC_SETS];
    logic [WAY_W-1:0] ptr_next;

    // at most one way hits since fills only happen on a miss
    always_comb begin
        o_hit      = 1'b0;
        o_hit_way  = '0;
        o_hit_data = '0;
        for (int w = 0; w < `MC_WAYS; w++) begin
            if (i_resp[w].hit) begin
                o_hit      = 1'b1;
                o_hit_way  = WAY_W'(w);
                o_hit_data = i_resp[w].data;
            end
        end
    end

    assign o_victim = rr_ptr[i_index];

    // wrap explicitly so a way count below 2**WAY_W still works
    always_comb begin
        if (rr_ptr[i_index] == WAY_W'(`MC_WAYS - 1)) begin
            ptr_next = '0;
        end else begin
            ptr_next = rr_ptr[i_index] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int s = 0; s < `MC_SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else if (i_fill_done) begin
            rr_ptr[i_index] <= ptr_next;
        end
    end

endmodule

// ==== hw/cache_ctrl.sv ====
`timescale 1ns/1ps
`include "mcache_macros.svh"

module cache_ctrl #(
    parameter int WAY_W = $clog2(`MC_WAYS)
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_lookup,
    input  mcache_pkg::cpu_req_t  i_req,
    input  logic                  i_hit,
    input  logic [WAY_W-1:0]      i_hit_way,
    input  logic [31:0]           i_hit_data,
    input  logic [WAY_W-1:0]      i_victim,
    input  logic                  i_mem_ack,
    input  logic [31:0]           i_mem_rdata,
    output logic                  o_mem_req,
    output mcache_pkg::mem_req_t  o_mem_cmd,
    output logic [`MC_WAYS-1:0]   o_fill_we,
    output logic [`MC_WAYS-1:0]   o_store_we,
    output logic [31:0]           o_fill_data,
    output logic                  o_fill_done,
    output logic [31:0]           o_rdata,
    output logic                  o_idle,
    output logic                  o_done
);
    typedef enum logic [2:0] {S_IDLE, S_CMP, S_MREQ, S_MWAIT, S_DONE} state_e;

    state_e state;
    state_e state_nxt;
    logic   cached_rd;
    logic   cached_wr;
    logic   rd_hit;
    logic   fill;

    function automatic logic [`MC_WAYS-1:0] way_onehot(input logic [WAY_W-1:0] way);
        logic [`MC_WAYS-1:0] vec;
        vec      = '0;
        vec[way] = 1'b1;
        return vec;
    endfunction

    assign cached_rd = !i_req.write && !i_req.uncache;
    assign cached_wr = i_req.write && !i_req.uncache;
    assign rd_hit    = (state == S_CMP) && cached_rd && i_hit;
    // a cached read that reached memory is a miss, fill once ack has fallen
    assign fill      = (state == S_MWAIT) && !i_mem_ack && cached_rd;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:  if (i_lookup) state_nxt = S_CMP;
            S_CMP:   state_nxt = rd_hit ? S_DONE : S_MREQ;
            S_MREQ:  if (i_mem_ack) state_nxt = S_MWAIT;
            S_MWAIT: if (!i_mem_ack) state_nxt = S_DONE;
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // memory command is built from the buffered request
    always_ff @(posedge clk) begin
        if (state == S_CMP) begin
            o_mem_cmd.addr  <= i_req.uncache ? i_req.addr.raw : {i_req.addr.raw[31:2], 2'b00};
            o_mem_cmd.wdata <= i_req.wdata;
            o_mem_cmd.wstrb <= i_req.write ? i_req.wstrb : 4'b0000;
            o_mem_cmd.write <= i_req.write;
        end
        if (rd_hit) begin
            o_rdata <= i_hit_data;
        end else if ((state == S_MREQ) && i_mem_ack && !i_req.write) begin
            o_rdata <= i_mem_rdata;
        end
    end

    assign o_mem_req   = (state == S_MREQ);
    assign o_idle      = (state == S_IDLE);
    // done on the edge that enters S_DONE, so a hit acks at the select edge
    assign o_done      = (state_nxt == S_DONE);
    assign o_fill_data = o_rdata;
    assign o_fill_done = fill;
    assign o_fill_we   = fill ? way_onehot(i_victim) : '0;
    // store hits update the way before the write goes out
    assign o_store_we  = ((state == S_CMP) && cached_wr && i_hit) ? way_onehot(i_hit_way) : '0;

endmodule

// ==== hw/mcache_top.sv ====
`timescale 1ns/1ps
`include "mcache_macros.svh"

module mcache_top (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_ireq,
    input  logic [31:0]          i_iaddr,
    output logic                 o_iack,
    output logic [31:0]          o_irdata,
    input  logic                 i_dreq,
    input  mcache_pkg::cpu_req_t i_dreq_data,
    output logic                 o_dack,
    output logic [31:0]          o_drdata,
    output logic                 o_mem_req,
    output mcache_pkg::mem_req_t o_mem_cmd,
    input  logic                 i_mem_ack,
    input  logic [31:0]          i_mem_rdata
);
    localparam int WAY_W = $clog2(`MC_WAYS);

    mcache_pkg::cpu_req_t                    req;
    mcache_pkg::req_src_e                    src;
    mcache_pkg::way_resp_t [`MC_WAYS-1:0]    resp;
    logic                                    lookup;
    logic                                    idle;
    logic                                    done;
    logic                                    hit;
    logic                                    fill_done;
    logic [WAY_W-1:0]                        hit_way;
    logic [WAY_W-1:0]                        victim;
    logic [31:0]                             hit_data;
    logic [31:0]                             fill_data;
    logic [31:0]                             rdata;
    logic [`MC_WAYS-1:0]                     fill_we;
    logic [`MC_WAYS-1:0]                     store_we;

    req_arbiter u_arb (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_ireq      (i_ireq),
        .i_iaddr     (i_iaddr),
        .i_dreq      (i_dreq),
        .i_dreq_data (i_dreq_data),
        .i_idle      (idle),
        .i_done      (done),
        .o_iack      (o_iack),
        .o_dack      (o_dack),
        .o_lookup    (lookup),
        .o_req       (req),
        .o_src       (src)
    );

    for (genvar g = 0; g < `MC_WAYS; g++) begin : g_way
        cache_way u_way (
            .clk         (clk),
            .i_rst_n     (i_rst_n),
            .i_lookup    (lookup),
            .i_req       (req),
            .i_fill_we   (fill_we[g]),
            .i_store_we  (store_we[g]),
            .i_fill_data (fill_data),
            .o_resp      (resp[g])
        );
    end

    way_select #(.WAY_W(WAY_W)) u_sel (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_resp      (resp),
        .i_index     (req.addr.f.index),
        .i_fill_done (fill_done),
        .o_hit       (hit),
        .o_hit_way   (hit_way),
        .o_hit_data  (hit_data),
        .o_victim    (victim)
    );

    cache_ctrl #(.WAY_W(WAY_W)) u_ctrl (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_lookup    (lookup),
        .i_req       (req),
        .i_hit       (hit),
        .i_hit_way   (hit_way),
        .i_hit_data  (hit_data),
        .i_victim    (victim),
        .i_mem_ack   (i_mem_ack),
        .i_mem_rdata (i_mem_rdata),
        .o_mem_req   (o_mem_req),
        .o_mem_cmd   (o_mem_cmd),
        .o_fill_we   (fill_we),
        .o_store_we  (store_we),
        .o_fill_data (fill_data),
        .o_fill_done (fill_done),
        .o_rdata     (rdata),
        .o_idle      (idle),
        .o_done      (done)
    );

    // return word goes only to the port that was granted
    assign o_irdata = (src == mcache_pkg::SRC_INST) ? rdata : 32'h0;
    assign o_drdata = (src == mcache_pkg::SRC_DATA) ? rdata : 32'h0;

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
    parameter logic [31:0] PATTERN   = 32'h0,
    parameter int          MAX_DELAY = 4
) (
    input  logic                 clk,
    input  logic                 i_req,
    input  mcache_pkg::mem_req_t i_cmd,
    output logic                 o_ack,
    output logic [31:0]          o_rdata,
    output int                   o_rd_count,
    output int                   o_wr_count
);
    // only written words are kept, the rest come from the fill pattern
    logic [31:0] words [logic [29:0]];
    integer      seed;
    int          delay;
    logic [31:0] cur;

    function automatic logic [31:0] stored_word(input logic [29:0] waddr);
        if (words.exists(waddr)) begin
            return words[waddr];
        end
        return {waddr, 2'b00} ^ PATTERN;
    endfunction

    initial begin
        seed       = 44814;
        o_rd_count = 0;
        o_wr_count = 0;
        o_ack   <= 1'b0;
        o_rdata <= 32'h0;
        forever begin
            @(posedge clk);
            if (i_req === 1'b1) begin
                delay = $unsigned($random(seed)) % MAX_DELAY;
                repeat (delay) @(posedge clk);
                cur = stored_word(i_cmd.addr[31:2]);
                if (i_cmd.write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (i_cmd.wstrb[b]) begin
                            cur[8*b +: 8] = i_cmd.wdata[8*b +: 8];
                        end
                    end
                    words[i_cmd.addr[31:2]] = cur;
                    o_wr_count++;
                end else begin
                    o_rdata <= cur;
                    o_rd_count++;
                end
                o_ack <= 1'b1;
                // hold ack until the cache lets go of req
                do @(posedge clk); while (i_req);
                o_ack <= 1'b0;
            end
        end
    end

endmodule

// ==== tb/mcache_tb.sv ====
`timescale 1ns/1ps

module mcache_tb;
    localparam logic [31:0] MEM_XOR = 32'h5A3C_96E1;
    localparam int HIT_EDGES = 3;
    // about 20 accesses of under 30 cycles each, with a wide margin
    localparam int TIMEOUT_CYCLES = 6000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 ireq;
    logic [31:0]          iaddr;
    logic                 iack;
    logic [31:0]          irdata;
    logic                 dreq;
    mcache_pkg::cpu_req_t dreq_data;
    logic                 dack;
    logic [31:0]          drdata;
    logic                 mem_req;
    mcache_pkg::mem_req_t mem_cmd;
    logic                 mem_ack;
    logic [31:0]          mem_rdata;
    int                   rd_count;
    int                   wr_count;
    int                   cycle_cnt = 0;
    int                   checks = 0;
    int                   test_errors = 0;
    int                   tests_passed = 0;
    int                   tests_failed = 0;
    string                test_name;
    // words the testbench stored, keyed by word address
    logic [31:0]          written [logic [29:0]];

    always #4 clk = ~clk;

    mcache_top i_dut (
        .clk         (clk),
        .i_rst_n     (rst_n),
        .i_ireq      (ireq),
        .i_iaddr     (iaddr),
        .o_iack      (iack),
        .o_irdata    (irdata),
        .i_dreq      (dreq),
        .i_dreq_data (dreq_data),
        .o_dack      (dack),
        .o_drdata    (drdata),
        .o_mem_req   (mem_req),
        .o_mem_cmd   (mem_cmd),
        .i_mem_ack   (mem_ack),
        .i_mem_rdata (mem_rdata)
    );

    mem_model #(.PATTERN(MEM_XOR)) u_mem (
        .clk        (clk),
        .i_req      (mem_req),
        .i_cmd      (mem_cmd),
        .o_ack      (mem_ack),
        .o_rdata    (mem_rdata),
        .o_rd_count (rd_count),
        .o_wr_count (wr_count)
    );

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // 26-bit tag, 4-bit index, word aligned
    function automatic logic [31:0] line_addr(input logic [25:0] tag, input logic [3:0] idx);
        return {tag, idx, 2'b00};
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (written.exists(addr[31:2])) begin
            return written[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ MEM_XOR;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // edges counts from the first edge that sees req up to the ack edge
    task automatic data_access(input logic wr, input logic unc, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strb,
                               output logic [31:0] rdata, output int edges);
        mcache_pkg::cpu_req_t r;
        int n;
        r          = '0;
        r.addr.raw = addr;
        r.wdata    = wdata;
        r.wstrb    = strb;
        r.write    = wr;
        r.uncache  = unc;
        n          = 0;
        @(posedge clk);
        dreq      <= 1'b1;
        dreq_data <= r;
        do begin
            @(posedge clk);
            n++;
        end while (!dack);
        rdata = drdata;
        edges = n - 1;
        dreq <= 1'b0;
        do @(posedge clk); while (dack);
    endtask

    task automatic inst_fetch(input logic [31:0] addr, output logic [31:0] rdata,
                              output int edges);
        int n;
        n = 0;
        @(posedge clk);
        ireq  <= 1'b1;
        iaddr <= addr;
        do begin
            @(posedge clk);
            n++;
        end while (!iack);
        rdata = irdata;
        edges = n - 1;
        ireq <= 1'b0;
        do @(posedge clk); while (iack);
    endtask

    // both ports raise req on the same edge
    task automatic dual_request(input logic [31:0] daddr, input logic [31:0] faddr,
                                output logic [31:0] d_rd, output logic [31:0] i_rd,
                                output int dack_at, output int iack_at);
        mcache_pkg::cpu_req_t r;
        int n;
        r          = '0;
        r.addr.raw = daddr;
        r.wstrb    = 4'b1111;
        n          = 0;
        dack_at    = 0;
        iack_at    = 0;
        @(posedge clk);
        dreq      <= 1'b1;
        dreq_data <= r;
        ireq      <= 1'b1;
        iaddr     <= faddr;
        while (dack_at == 0 || iack_at == 0 || dack || iack) begin
            @(posedge clk);
            n++;
            if (dack && dack_at == 0) begin
                dack_at = n;
                d_rd    = drdata;
                dreq   <= 1'b0;
            end
            if (iack && iack_at == 0) begin
                iack_at = n;
                i_rd    = irdata;
                ireq   <= 1'b0;
            end
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rd;
        logic [31:0] rd2;
        int          edges;
        int          rd0;
        int          wr0;
        int          d_at;
        int          i_at;

        rst_n     <= 1'b0;
        ireq      <= 1'b0;
        iaddr     <= 32'h0;
        dreq      <= 1'b0;
        dreq_data <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        start_test("read_miss_hit");
        a   = line_addr(26'h0012345, 4'h1);
        rd0 = rd_count;
        data_access(1'b0, 1'b0, a, 32'h0, 4'hf, rd, edges);
        check_value("miss data", expected_word(a), rd);
        check_value("miss reads", rd0 + 1, rd_count);
        data_access(1'b0, 1'b0, a, 32'h0, 4'hf, rd, edges);
        check_value("hit data", expected_word(a), rd);
        check_value("hit reads", rd0 + 1, rd_count);
        check_value("hit latency", HIT_EDGES, edges);
        end_test();

        start_test("write_through");
        rd0 = rd_count;
        wr0 = wr_count;
        data_access(1'b1, 1'b0, a, 32'hDEAD_BEEF, 4'b0101, rd, edges);
        written[a[31:2]] = merge_bytes(expected_word(a), 32'hDEAD_BEEF, 4'b0101);
        check_value("memory writes", wr0 + 1, wr_count);
        data_access(1'b0, 1'b0, a, 32'h0, 4'hf, rd, edges);
        check_value("merged data", expected_word(a), rd);
        check_value("reads after store", rd0, rd_count);
        // uncached read sees the word that reached memory
        data_access(1'b0, 1'b1, a, 32'h0, 4'hf, rd, edges);
        check_value("memory data", expected_word(a), rd);
        check_value("memory reads", rd0 + 1, rd_count);
        end_test();

        start_test("uncached");
        a   = line_addr(26'h00ABCDE, 4'h2);
        rd0 = rd_count;
        data_access(1'b0, 1'b1, a, 32'h0, 4'hf, rd, edges);
        check_value("first uncached data", expected_word(a), rd);
        data_access(1'b0, 1'b1, a, 32'h0, 4'hf, rd, edges);
        check_value("second uncached data", expected_word(a), rd);
        check_value("uncached reads", rd0 + 2, rd_count);
        data_access(1'b0, 1'b0, a, 32'h0, 4'hf, rd, edges);
        check_value("cached data", expected_word(a), rd);
        check_value("cached read misses", rd0 + 3, rd_count);
        end_test();

        start_test("round_robin");
        rd0 = rd_count;
        for (int i = 0; i < 5; i++) begin
            a = line_addr(26'h0100000 + 26'(i), 4'h9);
            data_access(1'b0, 1'b0, a, 32'h0, 4'hf, rd, edges);
            check_value("fill data", expected_word(a), rd);
        end
        check_value("fill reads", rd0 + 5, rd_count);
        // fifth fill wrapped onto way 0 and evicted the first tag
        a = line_addr(26'h0100000, 4'h9);
        data_access(1'b0, 1'b0, a, 32'h0, 4'hf, rd, edges);
        check_value("evicted data", expected_word(a), rd);
        check_value("evicted reads", rd0 + 6, rd_count);
        a = line_addr(26'h0100004, 4'h9);
        data_access(1'b0, 1'b0, a, 32'h0, 4'hf, rd, edges);
        check_value("kept data", expected_word(a), rd);
        check_value("kept reads", rd0 + 6, rd_count);
        end_test();

        start_test("inst_arbitration");
        a = line_addr(26'h0200001, 4'h5);
        b = line_addr(26'h0200002, 4'h6);
        dual_request(a, b, rd, rd2, d_at, i_at);
        assert (d_at < i_at) else begin
            $display("%s: the data ack did not come before the instruction ack", test_name);
            test_errors++;
        end
        check_value("data port data", expected_word(a), rd);
        check_value("fetch data", expected_word(b), rd2);
        rd0 = rd_count;
        inst_fetch(a, rd, edges);
        check_value("fetch hit data", expected_word(a), rd);
        check_value("fetch hit reads", rd0, rd_count);
        check_value("fetch hit latency", HIT_EDGES, edges);
        end_test();

        $display("tests passed %0d, failed %0d, checks %0d", tests_passed, tests_failed, checks);
        if (tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hw
hw/mcache_pkg.sv
hw/req_arbiter.sv
hw/cache_way.sv
hw/way_select.sv
hw/cache_ctrl.sv
hw/mcache_top.sv
tb/mem_model.sv
tb/mcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module mcache_tb \
    -Mdir obj_dir -o mcache_sim

./obj_dir/mcache_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
else
    exit 1
fi
